// ==== include/lmg_config.svh ====
`ifndef LMG_CONFIG_SVH
`define LMG_CONFIG_SVH

// board geometry, square index = rank * 8 + file
`define LMG_SQ_BITS 4
`define LMG_BOARD_BITS 256
`define LMG_FILES 8
`define LMG_BACK_RANK 0
`define LMG_EP_FROM_RANK 4
`define LMG_EP_TO_RANK 5

// top bit of a square
`define LMG_COLOR_WHITE 1'b0
`define LMG_COLOR_BLACK 1'b1

// low three bits of a square
`define LMG_PIECE_EMPTY 3'd0
`define LMG_PIECE_PAWN 3'd1
`define LMG_PIECE_KNIGHT 3'd2
`define LMG_PIECE_BISHOP 3'd3
`define LMG_PIECE_ROOK 3'd4
`define LMG_PIECE_QUEEN 3'd5
`define LMG_PIECE_KING 3'd6

// [invalid][promote][pawn move][pawn 2 sq][en passant][castle][capture]
`define LMG_FLAGS_CASTLE 7'b0000010
`define LMG_FLAGS_ENP 7'b0010101

// candidate table layout
`define LMG_NUM_SLOTS 16
`define LMG_SLOT_KSIDE 0
`define LMG_SLOT_QSIDE 1
`define LMG_SLOT_ENP_BASE 2

// one run never writes more than the slot count
`define LMG_FIFO_DEPTH 16

`endif

// ==== source/lmg_pkg.sv ====
`include "lmg_config.svh"

package lmg_pkg;

	typedef logic [`LMG_BOARD_BITS-1:0] board_t;
	typedef logic [`LMG_SQ_BITS-1:0] square_t; // {color, kind}
	typedef logic [5:0] coord_t; // {file, rank}
	typedef logic [6:0] move_flags_t;
	typedef logic [18:0] move_t; // {flags, from, to}
	typedef logic [$clog2(`LMG_NUM_SLOTS)-1:0] slot_t;
	typedef logic [7:0] enp_flags_t; // bit 0 is file a

	// run-once sequence
	typedef enum logic [1:0] {
		RSET,
		SNAP,
		SCAN,
		DONE
	} gen_state_t;

endpackage

// ==== source/scan_if.sv ====
`timescale 1ns/1ns

interface scan_if;

	logic capture; // one cycle, snapshot the board
	logic scan_en; // high for the whole walk
	lmg_pkg::slot_t slot;
	logic last; // slot is the final one

	modport fsm (
		output capture,
		output scan_en,
		input last
	);

	modport counter (
		input capture,
		input scan_en,
		output slot,
		output last
	);

	modport finder (
		input capture,
		input scan_en,
		input slot
	);

endinterface

// ==== source/gen_fsm.sv ====
`timescale 1ns/1ns
`include "lmg_config.svh"

module gen_fsm (
	input logic clk,
	input logic reset,
	scan_if.fsm sc,
	output logic done
);

	lmg_pkg::gen_state_t state;
	lmg_pkg::gen_state_t state_nxt;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= lmg_pkg::RSET;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			lmg_pkg::RSET: begin
				state_nxt = lmg_pkg::SNAP;
			end
			lmg_pkg::SNAP: begin
				state_nxt = lmg_pkg::SCAN;
			end
			lmg_pkg::SCAN: begin
				if (sc.last) begin
					state_nxt = lmg_pkg::DONE;
				end
			end
			lmg_pkg::DONE: begin
				state_nxt = lmg_pkg::DONE; // held until the next reset
			end
			default: begin
				state_nxt = lmg_pkg::RSET;
			end
		endcase
	end

	assign sc.capture = (state == lmg_pkg::SNAP);
	assign sc.scan_en = (state == lmg_pkg::SCAN);
	assign done = (state == lmg_pkg::DONE);

	// the walk visits every slot once, so SCAN lasts one cycle per slot
	a_scan_one_per_slot: assert property (
		@(posedge clk) disable iff (reset)
		$rose(done) |-> $past(sc.scan_en, `LMG_NUM_SLOTS)
			&& !$past(sc.scan_en, `LMG_NUM_SLOTS + 1)
	) else $error("scan did not last one cycle per slot");

endmodule

// ==== source/slot_counter.sv ====
`timescale 1ns/1ns
`include "lmg_config.svh"

module slot_counter (
	input logic clk,
	input logic reset,
	scan_if.counter sc
);

	localparam lmg_pkg::slot_t LAST_SLOT = lmg_pkg::slot_t'(`LMG_NUM_SLOTS - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			sc.slot <= '0;
		end else if (sc.capture) begin
			sc.slot <= '0;
		end else if (sc.scan_en && !sc.last) begin
			sc.slot <= sc.slot + 1'b1; // holds at the final slot
		end
	end

	assign sc.last = (sc.slot == LAST_SLOT);

	// the walk ends on the final slot, no second pass
	a_no_wrap: assert property (
		@(posedge clk) disable iff (reset)
		(sc.scan_en && sc.last) |=> (sc.slot != '0)
	) else $error("slot wrapped to 0 during the scan");

endmodule

// ==== source/special_move_finder.sv ====
`timescale 1ns/1ns
`include "lmg_config.svh"

module special_move_finder (
	input logic clk,
	input logic reset,
	input lmg_pkg::board_t bstate,
	input logic lcas_flag,
	input logic rcas_flag,
	input lmg_pkg::enp_flags_t enp_flags,
	scan_if.finder sc,
	output logic wr_en,
	output lmg_pkg::move_t wr_move
);

	localparam int NSLOT = `LMG_NUM_SLOTS;
	localparam int BR = `LMG_BACK_RANK;
	localparam int EP_FROM = `LMG_EP_FROM_RANK;
	localparam int EP_TO = `LMG_EP_TO_RANK;
	localparam lmg_pkg::square_t W_KING = {`LMG_COLOR_WHITE, `LMG_PIECE_KING};
	localparam lmg_pkg::square_t W_ROOK = {`LMG_COLOR_WHITE, `LMG_PIECE_ROOK};
	localparam lmg_pkg::square_t W_PAWN = {`LMG_COLOR_WHITE, `LMG_PIECE_PAWN};

	function automatic lmg_pkg::square_t sq_at(input lmg_pkg::board_t b, input int file,
			input int rank);
		return b[(rank * `LMG_FILES + file) * `LMG_SQ_BITS +: `LMG_SQ_BITS];
	endfunction

	function automatic lmg_pkg::coord_t coord(input int file, input int rank);
		return {file[2:0], rank[2:0]};
	endfunction

	// color bit is don't care on an empty square
	function automatic logic is_empty(input lmg_pkg::square_t s);
		return s[2:0] == `LMG_PIECE_EMPTY;
	endfunction

	logic cas_k;
	logic cas_q;
	wire [NSLOT-1:0] cand_valid;
	wire lmg_pkg::move_t cand_move [NSLOT];
	logic [NSLOT-1:0] valid_q;
	lmg_pkg::move_t move_q [NSLOT];

	// castling does not look at check or attacked squares on the king's path
	assign cas_k = (sq_at(bstate, 4, BR) == W_KING) // e1
		&& is_empty(sq_at(bstate, 5, BR))
		&& is_empty(sq_at(bstate, 6, BR))
		&& (sq_at(bstate, 7, BR) == W_ROOK) // h1
		&& rcas_flag;

	assign cas_q = (sq_at(bstate, 0, BR) == W_ROOK) // a1
		&& is_empty(sq_at(bstate, 1, BR))
		&& is_empty(sq_at(bstate, 2, BR))
		&& is_empty(sq_at(bstate, 3, BR))
		&& (sq_at(bstate, 4, BR) == W_KING)
		&& lcas_flag;

	assign cand_valid[`LMG_SLOT_KSIDE] = cas_k;
	assign cand_move[`LMG_SLOT_KSIDE] = {`LMG_FLAGS_CASTLE, coord(4, BR), coord(6, BR)}; // e1-g1
	assign cand_valid[`LMG_SLOT_QSIDE] = cas_q;
	assign cand_move[`LMG_SLOT_QSIDE] = {`LMG_FLAGS_CASTLE, coord(4, BR), coord(2, BR)}; // e1-c1

	// per target file t, capturer from file t-1 then from file t+1
	for (genvar t = 0; t < `LMG_FILES; t++) begin : g_enp
		if (t > 0) begin : g_from_lower
			assign cand_valid[`LMG_SLOT_ENP_BASE + 2 * t - 1] = enp_flags[t]
				&& (sq_at(bstate, t - 1, EP_FROM) == W_PAWN);
			assign cand_move[`LMG_SLOT_ENP_BASE + 2 * t - 1] =
				{`LMG_FLAGS_ENP, coord(t - 1, EP_FROM), coord(t, EP_TO)};
		end
		if (t < `LMG_FILES - 1) begin : g_from_upper
			assign cand_valid[`LMG_SLOT_ENP_BASE + 2 * t] = enp_flags[t]
				&& (sq_at(bstate, t + 1, EP_FROM) == W_PAWN);
			assign cand_move[`LMG_SLOT_ENP_BASE + 2 * t] =
				{`LMG_FLAGS_ENP, coord(t + 1, EP_FROM), coord(t, EP_TO)};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (sc.capture) begin
			valid_q <= cand_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sc.capture) begin
			move_q <= cand_move;
		end
	end

	// one slot per cycle, invalid slots are skipped
	assign wr_en = sc.scan_en && valid_q[sc.slot];
	assign wr_move = move_q[sc.slot];

endmodule

// ==== source/move_fifo.sv ====
`timescale 1ns/1ns
`include "lmg_config.svh"

module move_fifo (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input lmg_pkg::move_t wr_move,
	input logic rden,
	output lmg_pkg::move_t fifo_out,
	output logic fifo_empty
);

	localparam int DEPTH = `LMG_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	lmg_pkg::move_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == (PTR_W + 1)'(DEPTH));
	assign fifo_empty = (count == '0);
	assign push = wr_en && !full;
	assign pop = rden && !fifo_empty; // read strobe on an empty FIFO does nothing

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_move;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
		end
	end

	// show-ahead, oldest entry is always on the output
	assign fifo_out = mem[rd_ptr];

	// the finder has no back-pressure, so a full FIFO would drop a move
	a_no_write_full: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> !full
	) else $error("move written into a full FIFO");

endmodule

// ==== source/lmg_top.sv ====
`timescale 1ns/1ns

module lmg_top (
	input logic clk,
	input logic reset,
	input lmg_pkg::board_t bstate,
	input logic lcas_flag, // queenside rook and king unmoved
	input logic rcas_flag, // kingside rook and king unmoved
	input lmg_pkg::enp_flags_t enp_flags,
	input logic rden,
	output lmg_pkg::move_t fifo_out,
	output logic fifo_empty,
	output logic done
);

	logic wr_en;
	lmg_pkg::move_t wr_move;

	scan_if sc ();

	gen_fsm u_fsm (
		.clk (clk),
		.reset (reset),
		.sc (sc.fsm),
		.done (done)
	);

	slot_counter u_counter (
		.clk (clk),
		.reset (reset),
		.sc (sc.counter)
	);

	special_move_finder u_finder (
		.clk (clk),
		.reset (reset),
		.bstate (bstate),
		.lcas_flag (lcas_flag),
		.rcas_flag (rcas_flag),
		.enp_flags (enp_flags),
		.sc (sc.finder),
		.wr_en (wr_en),
		.wr_move (wr_move)
	);

	move_fifo u_fifo (
		.clk (clk),
		.reset (reset),
		.wr_en (wr_en),
		.wr_move (wr_move),
		.rden (rden),
		.fifo_out (fifo_out),
		.fifo_empty (fifo_empty)
	);

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

// ==== tb/tb_lmg.sv ====
`timescale 1ns/1ns
`include "lmg_config.svh"

module tb_lmg;

	localparam int CAP_RANK = 4; // rank 5
	localparam int DST_RANK = 5; // rank 6
	localparam int DONE_LIMIT = 30;
	localparam int FIFO_LIMIT = 10;
	localparam logic [3:0] W_PAWN = {`LMG_COLOR_WHITE, `LMG_PIECE_PAWN};
	localparam logic [3:0] B_PAWN = {`LMG_COLOR_BLACK, `LMG_PIECE_PAWN};
	localparam logic [3:0] W_ROOK = {`LMG_COLOR_WHITE, `LMG_PIECE_ROOK};
	localparam logic [3:0] W_KING = {`LMG_COLOR_WHITE, `LMG_PIECE_KING};
	localparam logic [3:0] W_BISHOP = {`LMG_COLOR_WHITE, `LMG_PIECE_BISHOP};

	logic clk;
	logic reset;
	lmg_pkg::board_t bstate;
	logic lcas_flag;
	logic rcas_flag;
	lmg_pkg::enp_flags_t enp_flags;
	logic rden;
	lmg_pkg::move_t fifo_out;
	logic fifo_empty;
	logic done;

	logic [31:0] seed;
	lmg_pkg::move_t exp_q [$]; // model output in slot order

	tb_clock u_clock (
		.clk (clk)
	);

	lmg_top dut (
		.clk (clk),
		.reset (reset),
		.bstate (bstate),
		.lcas_flag (lcas_flag),
		.rcas_flag (rcas_flag),
		.enp_flags (enp_flags),
		.rden (rden),
		.fifo_out (fifo_out),
		.fifo_empty (fifo_empty),
		.done (done)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [3:0] square_of(input int file, input int rank);
		return bstate[(rank * 8 + file) * 4 +: 4];
	endfunction

	function automatic logic vacant(input int file, input int rank);
		logic [3:0] s;
		s = square_of(file, rank);
		return s[2:0] == `LMG_PIECE_EMPTY;
	endfunction

	function automatic logic [5:0] where(input int file, input int rank);
		return {3'(file), 3'(rank)};
	endfunction

	task automatic put_piece(input int file, input int rank, input logic [3:0] piece);
		bstate[(rank * 8 + file) * 4 +: 4] = piece;
	endtask

	// expected moves straight from the castling and en passant rules
	function automatic void build_model();
		exp_q.delete();
		if (rcas_flag && square_of(4, 0) == W_KING && vacant(5, 0) && vacant(6, 0)
				&& square_of(7, 0) == W_ROOK) begin
			exp_q.push_back({`LMG_FLAGS_CASTLE, where(4, 0), where(6, 0)});
		end
		if (lcas_flag && square_of(0, 0) == W_ROOK && vacant(1, 0) && vacant(2, 0)
				&& vacant(3, 0) && square_of(4, 0) == W_KING) begin
			exp_q.push_back({`LMG_FLAGS_CASTLE, where(4, 0), where(2, 0)});
		end
		for (int t = 0; t < 8; t++) begin
			for (int side = -1; side <= 1; side += 2) begin
				int cap;
				cap = t + side; // lower file first
				if (cap >= 0 && cap < 8 && enp_flags[t] && square_of(cap, CAP_RANK) == W_PAWN) begin
					exp_q.push_back({`LMG_FLAGS_ENP, where(cap, CAP_RANK), where(t, DST_RANK)});
				end
			end
		end
	endfunction

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic start_run();
		int n;
		@(negedge clk);
		reset = 1'b1;
		rden = 1'b0;
		repeat (4) @(negedge clk);
		a_reset_state: assert (!done && fifo_empty) else fail_run($sformatf(
			"error at %0t ns: done=%b fifo_empty=%b in reset", $time, done, fifo_empty));
		reset = 1'b0;
		n = 0;
		while (!done && n < DONE_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!done) begin
			fail_run($sformatf("timeout: done did not rise within %0d cycles (at %0t ns)",
				DONE_LIMIT, $time));
		end
	endtask

	task automatic drain_and_check();
		int n;
		for (int i = 0; i < exp_q.size(); i++) begin
			n = 0;
			while (fifo_empty && n < FIFO_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (fifo_empty) begin
				fail_run($sformatf("timeout: FIFO empty while move %0d was expected (at %0t ns)",
					i, $time));
			end
			a_move: assert (fifo_out == exp_q[i]) else fail_run($sformatf(
				"error at %0t ns: entry %0d is %h, expected %h", $time, i, fifo_out, exp_q[i]));
			a_done_held: assert (done) else fail_run($sformatf(
				"error at %0t ns: done dropped while draining", $time));
			rden = 1'b1;
			@(negedge clk);
			rden = 1'b0;
		end
		a_drained: assert (fifo_empty) else fail_run($sformatf(
			"error at %0t ns: extra entry %h after the expected moves", $time, fifo_out));
		// read strobe on an empty FIFO
		rden = 1'b1;
		@(negedge clk);
		rden = 1'b0;
		@(negedge clk);
		a_empty_read: assert (fifo_empty && done) else fail_run($sformatf(
			"error at %0t ns: fifo_empty=%b done=%b after read while empty", $time, fifo_empty,
			done));
	endtask

	task automatic run_case();
		build_model();
		start_run();
		drain_and_check();
	endtask

	// the reader stays away, the oldest move must sit on fifo_out
	task automatic hold_and_watch(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			a_head_held: assert (done && !fifo_empty && fifo_out == exp_q[0]) else fail_run(
				$sformatf("error at %0t ns: head %h empty=%b done=%b, expected %h", $time,
				fifo_out, fifo_empty, done, exp_q[0]));
		end
	endtask

	task automatic castle_rank();
		bstate = '0;
		put_piece(0, 0, W_ROOK);
		put_piece(4, 0, W_KING);
		put_piece(7, 0, W_ROOK);
	endtask

	task automatic random_pawn_rank();
		bstate = '0;
		seed = lcg_next(seed);
		for (int f = 0; f < 8; f++) begin
			case (seed[16 + 2 * f +: 2])
				2'd0, 2'd3: put_piece(f, CAP_RANK, W_PAWN);
				2'd1: put_piece(f, CAP_RANK, B_PAWN);
				default: put_piece(f, CAP_RANK, '0);
			endcase
		end
		lcas_flag = seed[15];
		rcas_flag = seed[14];
	endtask

	initial begin
		reset = 1'b1;
		bstate = '0;
		lcas_flag = 1'b0;
		rcas_flag = 1'b0;
		enp_flags = '0;
		rden = 1'b0;
		seed = 32'h854ced2a;

		// empty board, nothing to write
		run_case();

		castle_rank();
		lcas_flag = 1'b1;
		rcas_flag = 1'b1;
		run_case();
		rcas_flag = 1'b0;
		run_case();
		lcas_flag = 1'b0;
		rcas_flag = 1'b1;
		run_case();
		lcas_flag = 1'b1;
		put_piece(5, 0, W_BISHOP); // f1 blocks the kingside
		run_case();

		for (int t = 0; t < 8; t++) begin
			for (int k = 0; k < 3; k++) begin
				random_pawn_rank();
				if (k == 0) begin // both neighbors white on the first try
					if (t > 0) begin
						put_piece(t - 1, CAP_RANK, W_PAWN);
					end
					if (t < 7) begin
						put_piece(t + 1, CAP_RANK, W_PAWN);
					end
				end
				enp_flags = 8'(1 << t);
				run_case();
			end
		end

		castle_rank();
		lcas_flag = 1'b1;
		rcas_flag = 1'b1;
		for (int f = 0; f < 8; f += 2) begin
			put_piece(f, CAP_RANK, W_PAWN);
		end
		enp_flags = 8'b1010_1010;
		build_model();
		start_run();
		hold_and_watch(20);
		drain_and_check();

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
source/lmg_pkg.sv
source/scan_if.sv
source/gen_fsm.sv
source/slot_counter.sv
source/special_move_finder.sv
source/move_fifo.sv
source/lmg_top.sv
tb/tb_clock.sv
tb/tb_lmg.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_lmg -o tb_lmg
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_lmg > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi

grep -q "^All checks passed$" sim.log
if [ $? -ne 0 ]; then
	echo "pass message not found in sim.log"
	exit 1
fi

exit 0
